// File: compile.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/mem_stage.sv
design/data_ram.sv
design/wb_stage.sv
design/mem_wb_top.sv
tests/tb_mem_wb.sv

// File: design/data_ram.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module data_ram (
  input  logic               clk,
  input  logic               rst,
  input  logic               rw_valid,
  input  logic               rw_write,
  input  logic [`XLEN-1:0]   rw_addr,
  input  logic [`XLEN-1:0]   rw_wdata,
  input  isa_pkg::size_e     rw_size,
  output logic               rw_ready,
  output logic [`XLEN-1:0]   rw_rdata,
  output isa_pkg::resp_e     rw_resp
);

  import isa_pkg::*;

  localparam int DEPTH = 1 << `DMEM_WORDS_LOG2;
  localparam int CW    = ($clog2(`DMEM_WAIT + 1) > 0) ? $clog2(`DMEM_WAIT + 1) : 1;
  localparam logic [CW-1:0] WAIT_CNT = CW'(`DMEM_WAIT);

  logic [`XLEN-1:0]           mem [0:DEPTH-1];
  logic [CW-1:0]              wait_cnt;
  logic [`DMEM_WORDS_LOG2-1:0] word_idx;
  logic [2:0]                 offset;
  logic                       misaligned;
  logic                       out_of_range;
  logic                       err;
  logic [7:0]                 lanes;
  logic [`XLEN-1:0]           wdata_shift;
  logic [`XLEN-1:0]           rdata_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (!rw_valid || rw_ready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign rw_ready = rw_valid && (wait_cnt == WAIT_CNT);

  assign word_idx     = rw_addr[`DMEM_WORDS_LOG2+2:3];
  assign offset       = rw_addr[2:0];
  assign out_of_range = |rw_addr[`XLEN-1:`DMEM_WORDS_LOG2+3];

  always_comb begin
    case (rw_size)
      SIZE_B:  misaligned = 1'b0;
      SIZE_H:  misaligned = offset[0];
      SIZE_W:  misaligned = |offset[1:0];
      default: misaligned = |offset;
    endcase
  end

  assign err     = misaligned || out_of_range;
  assign rw_resp = err ? RESP_ERROR : RESP_OKAY;

  // byte lanes touched by the access
  always_comb begin
    case (rw_size)
      SIZE_B:  lanes = 8'h01 << offset;
      SIZE_H:  lanes = 8'h03 << offset;
      SIZE_W:  lanes = 8'h0f << offset;
      default: lanes = 8'hff;
    endcase
  end

  assign wdata_shift = rw_wdata << {offset, 3'b000};

  always_ff @(posedge clk) begin
    if (rw_valid && rw_ready && rw_write && !err) begin
      for (int i = 0; i < 8; i++) begin
        if (lanes[i]) begin
          mem[word_idx][i*8 +: 8] <= wdata_shift[i*8 +: 8];
        end
      end
    end
  end

  assign rdata_shift = mem[word_idx] >> {offset, 3'b000};

  always_comb begin
    case (rw_size)
      SIZE_B:  rw_rdata = `XLEN'(rdata_shift[7:0]);
      SIZE_H:  rw_rdata = `XLEN'(rdata_shift[15:0]);
      SIZE_W:  rw_rdata = `XLEN'(rdata_shift[31:0]);
      default: rw_rdata = rdata_shift;
    endcase
  end

  a_req_known: assert property (@(posedge clk) disable iff (rst)
    rw_valid |-> !$isunknown(rw_size) && !$isunknown(rw_addr));

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

  typedef enum logic [2:0] {
    LOAD_NONE = 3'd0,
    LOAD_LB   = 3'd1,
    LOAD_LH   = 3'd2,
    LOAD_LW   = 3'd3,
    LOAD_LD   = 3'd4,
    LOAD_LBU  = 3'd5,
    LOAD_LHU  = 3'd6,
    LOAD_LWU  = 3'd7
  } load_op_e;

  typedef enum logic [2:0] {
    STORE_NONE = 3'd0,
    STORE_SB   = 3'd1,
    STORE_SH   = 3'd2,
    STORE_SW   = 3'd3,
    STORE_SD   = 3'd4
  } store_op_e;

  // access size in bytes is 1 << size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  typedef enum logic [1:0] {
    RESP_OKAY  = 2'b00,
    RESP_ERROR = 2'b10
  } resp_e;

endpackage

// File: design/mem_stage.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_stage (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   ex_valid,
  input  logic [`XLEN-1:0]       ex_pc,
  input  logic [31:0]            ex_inst,
  input  logic [`XLEN-1:0]       ex_addr,
  input  logic [`XLEN-1:0]       ex_store_data,
  input  logic [`XLEN-1:0]       ex_result,
  input  logic [`XLEN-1:0]       ex_csr_data,
  input  isa_pkg::load_op_e      ex_load_op,
  input  isa_pkg::store_op_e     ex_store_op,
  input  logic [`REG_AW-1:0]     ex_rd,
  input  logic                   ex_rd_we,
  input  pipe_pkg::wb_sel_e      ex_wb_sel,
  output logic                   mem_allowin,

  output logic                   mem_to_wb_valid,
  input  logic                   wb_allowin,
  output logic [`XLEN-1:0]       mem_pc,
  output logic [31:0]            mem_inst,
  output logic [`REG_AW-1:0]     mem_rd,
  output logic                   mem_rd_we,
  output pipe_pkg::wb_sel_e      mem_wb_sel,
  output logic [`XLEN-1:0]       mem_result,
  output logic [`XLEN-1:0]       mem_load_data,
  output logic [`XLEN-1:0]       mem_csr_data,
  output logic                   mem_fault,

  output logic [`REG_AW-1:0]     fwd_rd,
  output logic                   fwd_we,
  output logic [`XLEN-1:0]       fwd_data,

  output logic                   rw_valid,
  input  logic                   rw_ready,
  output logic                   rw_write,
  output logic [`XLEN-1:0]       rw_addr,
  output logic [`XLEN-1:0]       rw_wdata,
  output isa_pkg::size_e         rw_size,
  input  logic [`XLEN-1:0]       rw_rdata,
  input  isa_pkg::resp_e         rw_resp
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic             mem_valid;
  logic             ready_go;
  logic             ex_fire;
  logic             ex_is_mem;
  logic             rw_fire;
  mem_state_e       state_q;
  mem_state_e       state_d;
  load_op_e         load_op_q;
  store_op_e        store_op_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] store_data_q;
  logic [`XLEN-1:0] load_ext;

  assign ex_is_mem = (ex_load_op != LOAD_NONE) || (ex_store_op != STORE_NONE);
  assign ex_fire   = ex_valid && mem_allowin;
  assign rw_fire   = rw_valid && rw_ready;

  // non-memory items are done as soon as they arrive
  assign ready_go = (state_q == MEM_RETN) ||
                    ((load_op_q == LOAD_NONE) && (store_op_q == STORE_NONE));
  assign mem_allowin     = !mem_valid || (ready_go && wb_allowin);
  assign mem_to_wb_valid = mem_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid  <= 1'b0;
      load_op_q  <= LOAD_NONE;
      store_op_q <= STORE_NONE;
    end else if (mem_allowin) begin
      mem_valid  <= ex_valid;
      load_op_q  <= ex_valid ? ex_load_op : LOAD_NONE;
      store_op_q <= ex_valid ? ex_store_op : STORE_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin
      mem_pc       <= ex_pc;
      mem_inst     <= ex_inst;
      mem_rd       <= ex_rd;
      mem_rd_we    <= ex_rd_we;
      mem_wb_sel   <= ex_wb_sel;
      mem_result   <= ex_result;
      mem_csr_data <= ex_csr_data;
      addr_q       <= ex_addr;
      store_data_q <= ex_store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MEM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      MEM_IDLE: begin
        if (ex_fire && ex_is_mem) begin
          state_d = MEM_ADDR;
        end
      end
      MEM_ADDR: begin
        if (rw_ready) begin
          state_d = MEM_RETN;
        end
      end
      MEM_RETN: begin
        // item leaves this edge, next one may start a request right away
        if (mem_allowin) begin
          state_d = (ex_fire && ex_is_mem) ? MEM_ADDR : MEM_IDLE;
        end
      end
      default: state_d = MEM_IDLE;
    endcase
  end

  assign rw_valid = (state_q == MEM_ADDR);
  assign rw_write = (store_op_q != STORE_NONE);
  assign rw_addr  = addr_q;

  always_comb begin
    rw_size = SIZE_D;
    case (load_op_q)
      LOAD_LB, LOAD_LBU: rw_size = SIZE_B;
      LOAD_LH, LOAD_LHU: rw_size = SIZE_H;
      LOAD_LW, LOAD_LWU: rw_size = SIZE_W;
      default: ;
    endcase
    case (store_op_q)
      STORE_SB: rw_size = SIZE_B;
      STORE_SH: rw_size = SIZE_H;
      STORE_SW: rw_size = SIZE_W;
      default: ;
    endcase
  end

  // only the low bytes of the store are meaningful
  always_comb begin
    case (rw_size)
      SIZE_B:  rw_wdata = `XLEN'(store_data_q[7:0]);
      SIZE_H:  rw_wdata = `XLEN'(store_data_q[15:0]);
      SIZE_W:  rw_wdata = `XLEN'(store_data_q[31:0]);
      default: rw_wdata = store_data_q;
    endcase
  end

  always_comb begin
    case (load_op_q)
      LOAD_LB:  load_ext = {{(`XLEN-8){rw_rdata[7]}}, rw_rdata[7:0]};
      LOAD_LH:  load_ext = {{(`XLEN-16){rw_rdata[15]}}, rw_rdata[15:0]};
      LOAD_LW:  load_ext = {{(`XLEN-32){rw_rdata[31]}}, rw_rdata[31:0]};
      LOAD_LBU: load_ext = `XLEN'(rw_rdata[7:0]);
      LOAD_LHU: load_ext = `XLEN'(rw_rdata[15:0]);
      LOAD_LWU: load_ext = `XLEN'(rw_rdata[31:0]);
      default:  load_ext = rw_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rw_fire) begin
      mem_load_data <= load_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_fault <= 1'b0;
    end else if (rw_fire) begin
      mem_fault <= (rw_resp != RESP_OKAY);
    end else if (ex_fire) begin
      mem_fault <= 1'b0;
    end
  end

  // view of the pending register write, load value valid once done
  assign fwd_rd = mem_valid ? mem_rd : '0;
  assign fwd_we = mem_valid && mem_rd_we;

  always_comb begin
    fwd_data = '0;
    if (mem_valid) begin
      case (mem_wb_sel)
        WB_SEL_LOAD: fwd_data = mem_load_data;
        WB_SEL_CSR:  fwd_data = mem_csr_data;
        default:     fwd_data = mem_result;
      endcase
    end
  end

  // request held unchanged until data memory answers
  a_rw_stable: assert property (@(posedge clk) disable iff (rst)
    rw_valid && !rw_ready |=> rw_valid && $stable(rw_addr) && $stable(rw_wdata) &&
                              $stable(rw_size) && $stable(rw_write));

  a_one_mem_op: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> !((ex_load_op != LOAD_NONE) && (ex_store_op != STORE_NONE)));

endmodule

// File: design/mem_wb_top.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_wb_top (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 ex_valid,
  input  logic [`XLEN-1:0]     ex_pc,
  input  logic [31:0]          ex_inst,
  input  logic [`XLEN-1:0]     ex_addr,
  input  logic [`XLEN-1:0]     ex_store_data,
  input  logic [`XLEN-1:0]     ex_result,
  input  logic [`XLEN-1:0]     ex_csr_data,
  input  isa_pkg::load_op_e    ex_load_op,
  input  isa_pkg::store_op_e   ex_store_op,
  input  logic [`REG_AW-1:0]   ex_rd,
  input  logic                 ex_rd_we,
  input  pipe_pkg::wb_sel_e    ex_wb_sel,
  output logic                 mem_allowin,

  output logic [`REG_AW-1:0]   fwd_rd,
  output logic                 fwd_we,
  output logic [`XLEN-1:0]     fwd_data,

  output logic                 retire_valid,
  input  logic                 retire_ready,
  output logic [`XLEN-1:0]     retire_pc,
  output logic [31:0]          retire_inst,
  output logic [`REG_AW-1:0]   retire_rd,
  output logic                 retire_we,
  output logic [`XLEN-1:0]     retire_data,
  output logic                 retire_fault
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // memory stage to writeback
  logic               mem_to_wb_valid;
  logic               wb_allowin;
  logic [`XLEN-1:0]   mem_pc;
  logic [31:0]        mem_inst;
  logic [`REG_AW-1:0] mem_rd;
  logic               mem_rd_we;
  wb_sel_e            mem_wb_sel;
  logic [`XLEN-1:0]   mem_result;
  logic [`XLEN-1:0]   mem_load_data;
  logic [`XLEN-1:0]   mem_csr_data;
  logic               mem_fault;

  // data memory request port
  logic               rw_valid;
  logic               rw_ready;
  logic               rw_write;
  logic [`XLEN-1:0]   rw_addr;
  logic [`XLEN-1:0]   rw_wdata;
  size_e              rw_size;
  logic [`XLEN-1:0]   rw_rdata;
  resp_e              rw_resp;

  mem_stage u_mem_stage (
    .clk             (clk),
    .rst             (rst),
    .ex_valid        (ex_valid),
    .ex_pc           (ex_pc),
    .ex_inst         (ex_inst),
    .ex_addr         (ex_addr),
    .ex_store_data   (ex_store_data),
    .ex_result       (ex_result),
    .ex_csr_data     (ex_csr_data),
    .ex_load_op      (ex_load_op),
    .ex_store_op     (ex_store_op),
    .ex_rd           (ex_rd),
    .ex_rd_we        (ex_rd_we),
    .ex_wb_sel       (ex_wb_sel),
    .mem_allowin     (mem_allowin),
    .mem_to_wb_valid (mem_to_wb_valid),
    .wb_allowin      (wb_allowin),
    .mem_pc          (mem_pc),
    .mem_inst        (mem_inst),
    .mem_rd          (mem_rd),
    .mem_rd_we       (mem_rd_we),
    .mem_wb_sel      (mem_wb_sel),
    .mem_result      (mem_result),
    .mem_load_data   (mem_load_data),
    .mem_csr_data    (mem_csr_data),
    .mem_fault       (mem_fault),
    .fwd_rd          (fwd_rd),
    .fwd_we          (fwd_we),
    .fwd_data        (fwd_data),
    .rw_valid        (rw_valid),
    .rw_ready        (rw_ready),
    .rw_write        (rw_write),
    .rw_addr         (rw_addr),
    .rw_wdata        (rw_wdata),
    .rw_size         (rw_size),
    .rw_rdata        (rw_rdata),
    .rw_resp         (rw_resp)
  );

  data_ram u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .rw_valid (rw_valid),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_wdata (rw_wdata),
    .rw_size  (rw_size),
    .rw_ready (rw_ready),
    .rw_rdata (rw_rdata),
    .rw_resp  (rw_resp)
  );

  wb_stage u_wb_stage (
    .clk             (clk),
    .rst             (rst),
    .mem_to_wb_valid (mem_to_wb_valid),
    .wb_allowin      (wb_allowin),
    .mem_pc          (mem_pc),
    .mem_inst        (mem_inst),
    .mem_rd          (mem_rd),
    .mem_rd_we       (mem_rd_we),
    .mem_wb_sel      (mem_wb_sel),
    .mem_result      (mem_result),
    .mem_load_data   (mem_load_data),
    .mem_csr_data    (mem_csr_data),
    .mem_fault       (mem_fault),
    .retire_valid    (retire_valid),
    .retire_ready    (retire_ready),
    .retire_pc       (retire_pc),
    .retire_inst     (retire_inst),
    .retire_rd       (retire_rd),
    .retire_we       (retire_we),
    .retire_data     (retire_data),
    .retire_fault    (retire_fault)
  );

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

  // memory stage request state
  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,
    MEM_ADDR = 2'd1,
    MEM_RETN = 2'd2
  } mem_state_e;

  // source of the value written back to rd
  typedef enum logic [1:0] {
    WB_SEL_ALU  = 2'd0,
    WB_SEL_LOAD = 2'd1,
    WB_SEL_CSR  = 2'd2
  } wb_sel_e;

endpackage

// File: design/wb_stage.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module wb_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 mem_to_wb_valid,
  output logic                 wb_allowin,
  input  logic [`XLEN-1:0]     mem_pc,
  input  logic [31:0]          mem_inst,
  input  logic [`REG_AW-1:0]   mem_rd,
  input  logic                 mem_rd_we,
  input  pipe_pkg::wb_sel_e    mem_wb_sel,
  input  logic [`XLEN-1:0]     mem_result,
  input  logic [`XLEN-1:0]     mem_load_data,
  input  logic [`XLEN-1:0]     mem_csr_data,
  input  logic                 mem_fault,

  output logic                 retire_valid,
  input  logic                 retire_ready,
  output logic [`XLEN-1:0]     retire_pc,
  output logic [31:0]          retire_inst,
  output logic [`REG_AW-1:0]   retire_rd,
  output logic                 retire_we,
  output logic [`XLEN-1:0]     retire_data,
  output logic                 retire_fault
);

  import pipe_pkg::*;

  logic             wb_valid;
  logic [`XLEN-1:0] sel_data;

  assign wb_allowin   = !wb_valid || retire_ready;
  assign retire_valid = wb_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_comb begin
    case (mem_wb_sel)
      WB_SEL_LOAD: sel_data = mem_load_data;
      WB_SEL_CSR:  sel_data = mem_csr_data;
      default:     sel_data = mem_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_to_wb_valid && wb_allowin) begin
      retire_pc    <= mem_pc;
      retire_inst  <= mem_inst;
      retire_rd    <= mem_rd;
      // x0 is hardwired, faulting items never write
      retire_we    <= mem_rd_we && !mem_fault && (mem_rd != '0);
      retire_data  <= sel_data;
      retire_fault <= mem_fault;
    end
  end

  a_retire_hold: assert property (@(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc) &&
      $stable(retire_inst) && $stable(retire_rd) && $stable(retire_we) &&
      $stable(retire_data) && $stable(retire_fault));

endmodule

// File: include/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data and address width
`define XLEN 64

// register file address width
`define REG_AW 5

// data memory holds 2**DMEM_WORDS_LOG2 words of XLEN bits
`define DMEM_WORDS_LOG2 8

// cycles from rw_valid rising until rw_ready
`define DMEM_WAIT 2

`endif

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_mem_wb

# the simulator output goes to the terminal and to the search at once
if ./obj_dir/Vtb_mem_wb | tee /dev/stderr | grep -x "Testbench passed" > /dev/null; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

// File: tests/mem_wb_input.txt
# pc inst load_op store_op addr store_data result csr_data rd rd_we wb_sel (all hex)
# then expected retire_data retire_we retire_fault; retire_data is ignored on faults
80000000 00b500b3 0 0 0 0 0123456789abcdef 0 1 1 0 0123456789abcdef 1 0
80000004 30002173 0 0 0 0 1111 8000000000001800 2 1 2 8000000000001800 1 0
80000008 00b50033 0 0 0 0 deadbeef 0 0 1 0 deadbeef 0 0
8000000c 00500193 0 0 0 0 5 0 3 0 0 5 0 0
80000010 00b53023 0 4 100 8877665544332211 100 0 0 0 0 100 0 0
80000014 10053203 4 0 100 0 100 0 4 1 1 8877665544332211 1 0
80000018 10750283 1 0 107 0 107 0 5 1 1 ffffffffffffff88 1 0
8000001c 10754303 5 0 107 0 107 0 6 1 1 88 1 0
80000020 10651383 2 0 106 0 106 0 7 1 1 ffffffffffff8877 1 0
80000024 10255403 6 0 102 0 102 0 8 1 1 4433 1 0
80000028 10452483 3 0 104 0 104 0 9 1 1 ffffffff88776655 1 0
8000002c 10456503 7 0 104 0 104 0 a 1 1 88776655 1 0
80000030 10052583 3 0 100 0 100 0 b 1 1 44332211 1 0
80000034 0ab500a3 0 1 101 ffffffffffffffa5 101 0 0 0 0 101 0 0
80000038 0ac51323 0 2 106 cafe00001234 106 0 0 0 0 106 0 0
8000003c 0ad52423 0 3 108 99999999f00dface 108 0 0 0 0 108 0 0
80000040 10053603 4 0 100 0 100 0 c 1 1 123466554433a511 1 0
80000044 10150683 1 0 101 0 101 0 d 1 1 ffffffffffffffa5 1 0
80000048 10655703 6 0 106 0 106 0 e 1 1 1234 1 0
8000004c 10051783 2 0 100 0 100 0 f 1 1 ffffffffffffa511 1 0
80000050 10852803 3 0 108 0 108 0 10 1 1 fffffffff00dface 1 0
80000054 10a54883 5 0 10a 0 10a 0 11 1 1 d 1 0
80000058 10950003 1 0 109 0 109 0 0 1 1 fffffffffffffffa 0 0
8000005c 10252903 3 0 102 0 102 0 12 1 1 0 0 1
80000060 0ae53223 0 4 104 ffffffffffffffff 104 0 0 0 0 104 0 1
80000064 0a0510a3 0 2 101 0 101 0 0 0 0 101 0 1
80000068 0af53023 0 4 1100 0 1100 0 0 0 0 1100 0 1
8000006c 90053983 4 0 900 0 900 0 13 1 1 0 0 1
80000070 10053a03 4 0 100 0 100 0 14 1 1 123466554433a511 1 0
80000074 10651a83 2 0 106 0 106 0 15 1 1 1234 1 0
80000078 00c58b33 0 0 0 0 42 0 16 1 0 42 1 0
8000007c 30002073 0 0 0 0 0 300 0 1 2 300 0 0
80000080 00d60bb3 0 0 0 0 fedcba9876543210 0 17 1 0 fedcba9876543210 1 0
80000084 34202c73 0 0 0 0 9 b 18 1 2 b 1 0
80000088 01c68cb3 0 0 0 0 7fffffffffffffff 0 19 1 0 7fffffffffffffff 1 0
8000008c 00000013 0 0 0 0 0 0 0 0 0 0 0 0
80000090 10854d03 5 0 108 0 108 0 1a 1 1 ce 1 0
80000094 01d70db3 0 0 0 0 aaaa5555 0 1b 1 0 aaaa5555 1 0

// File: tests/tb_mem_wb.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module tb_mem_wb;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int MAX_VEC      = 128;
  localparam int ACCEPT_LIMIT = 200;
  localparam int RETIRE_LIMIT = 4000;

  logic               clk = 1'b0;
  logic               rst;
  logic               ex_valid;
  logic [`XLEN-1:0]   ex_pc;
  logic [31:0]        ex_inst;
  logic [`XLEN-1:0]   ex_addr;
  logic [`XLEN-1:0]   ex_store_data;
  logic [`XLEN-1:0]   ex_result;
  logic [`XLEN-1:0]   ex_csr_data;
  load_op_e           ex_load_op;
  store_op_e          ex_store_op;
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_rd_we;
  wb_sel_e            ex_wb_sel;
  logic               mem_allowin;
  logic [`REG_AW-1:0] fwd_rd;
  logic               fwd_we;
  logic [`XLEN-1:0]   fwd_data;
  logic               retire_valid;
  logic               retire_ready;
  logic [`XLEN-1:0]   retire_pc;
  logic [31:0]        retire_inst;
  logic [`REG_AW-1:0] retire_rd;
  logic               retire_we;
  logic [`XLEN-1:0]   retire_data;
  logic               retire_fault;

  // one entry per instruction, in program order
  logic [`XLEN-1:0]   v_pc [MAX_VEC];
  logic [31:0]        v_inst [MAX_VEC];
  logic [2:0]         v_lop [MAX_VEC];
  logic [2:0]         v_sop [MAX_VEC];
  logic [`XLEN-1:0]   v_addr [MAX_VEC];
  logic [`XLEN-1:0]   v_sdata [MAX_VEC];
  logic [`XLEN-1:0]   v_result [MAX_VEC];
  logic [`XLEN-1:0]   v_csr [MAX_VEC];
  logic [`REG_AW-1:0] v_rd [MAX_VEC];
  logic               v_rd_we [MAX_VEC];
  logic [1:0]         v_wb_sel [MAX_VEC];
  logic [`XLEN-1:0]   v_exp_data [MAX_VEC];
  logic               v_exp_we [MAX_VEC];
  logic               v_exp_fault [MAX_VEC];

  int                 n_vec;
  int                 ret_idx;
  integer             seed = 48;
  int                 rnd;

  // snapshot of a stalled retire record
  logic               held;
  logic [`XLEN-1:0]   held_pc;
  logic [31:0]        held_inst;
  logic [`REG_AW-1:0] held_rd;
  logic               held_we;
  logic [`XLEN-1:0]   held_data;
  logic               held_fault;

  mem_wb_top uut (
    .clk           (clk),
    .rst           (rst),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_inst       (ex_inst),
    .ex_addr       (ex_addr),
    .ex_store_data (ex_store_data),
    .ex_result     (ex_result),
    .ex_csr_data   (ex_csr_data),
    .ex_load_op    (ex_load_op),
    .ex_store_op   (ex_store_op),
    .ex_rd         (ex_rd),
    .ex_rd_we      (ex_rd_we),
    .ex_wb_sel     (ex_wb_sel),
    .mem_allowin   (mem_allowin),
    .fwd_rd        (fwd_rd),
    .fwd_we        (fwd_we),
    .fwd_data      (fwd_data),
    .retire_valid  (retire_valid),
    .retire_ready  (retire_ready),
    .retire_pc     (retire_pc),
    .retire_inst   (retire_inst),
    .retire_rd     (retire_rd),
    .retire_we     (retire_we),
    .retire_data   (retire_data),
    .retire_fault  (retire_fault)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_vectors();
    int                 fd;
    int                 code;
    int                 cnt;
    string              line;
    logic [`XLEN-1:0]   t_pc;
    logic [31:0]        t_inst;
    logic [2:0]         t_lop;
    logic [2:0]         t_sop;
    logic [`XLEN-1:0]   t_addr;
    logic [`XLEN-1:0]   t_sdata;
    logic [`XLEN-1:0]   t_result;
    logic [`XLEN-1:0]   t_csr;
    logic [`REG_AW-1:0] t_rd;
    logic               t_rd_we;
    logic [1:0]         t_wb_sel;
    logic [`XLEN-1:0]   t_exp_data;
    logic               t_exp_we;
    logic               t_exp_fault;
    fd = $fopen("tests/mem_wb_input.txt", "r");
    if (fd == 0) abort_run("cannot open the stimulus file");
    n_vec = 0;
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // skip comment and blank lines
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      t_pc, t_inst, t_lop, t_sop, t_addr, t_sdata, t_result, t_csr,
                      t_rd, t_rd_we, t_wb_sel, t_exp_data, t_exp_we, t_exp_fault);
        if (cnt != 14) abort_run("malformed line in the stimulus file");
        if (n_vec >= MAX_VEC) abort_run("too many entries in the stimulus file");
        v_pc[n_vec]        = t_pc;
        v_inst[n_vec]      = t_inst;
        v_lop[n_vec]       = t_lop;
        v_sop[n_vec]       = t_sop;
        v_addr[n_vec]      = t_addr;
        v_sdata[n_vec]     = t_sdata;
        v_result[n_vec]    = t_result;
        v_csr[n_vec]       = t_csr;
        v_rd[n_vec]        = t_rd;
        v_rd_we[n_vec]     = t_rd_we;
        v_wb_sel[n_vec]    = t_wb_sel;
        v_exp_data[n_vec]  = t_exp_data;
        v_exp_we[n_vec]    = t_exp_we;
        v_exp_fault[n_vec] = t_exp_fault;
        n_vec = n_vec + 1;
      end
    end
    $fclose(fd);
    if (n_vec == 0) abort_run("the stimulus file holds no entries");
  endtask

  // random back-pressure on the retire port, low about 3 cycles in 8
  always @(posedge clk) begin
    rnd = $random(seed);
    retire_ready <= (rnd[2:0] > 3'd2);
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (held) begin
        assert (retire_valid) else abort_run("retire_valid dropped while the record was stalled");
        check_val("retire_pc (stalled)", held_pc, retire_pc);
        check_val("retire_inst (stalled)", 64'(held_inst), 64'(retire_inst));
        check_val("retire_rd (stalled)", 64'(held_rd), 64'(retire_rd));
        check_val("retire_we (stalled)", 64'(held_we), 64'(retire_we));
        check_val("retire_data (stalled)", held_data, retire_data);
        check_val("retire_fault (stalled)", 64'(held_fault), 64'(retire_fault));
      end
      if (retire_valid && retire_ready) begin
        assert (ret_idx < n_vec) else abort_run("retirement beyond the last expected entry");
        check_val("retire_pc", v_pc[ret_idx], retire_pc);
        check_val("retire_inst", 64'(v_inst[ret_idx]), 64'(retire_inst));
        check_val("retire_rd", 64'(v_rd[ret_idx]), 64'(retire_rd));
        check_val("retire_we", 64'(v_exp_we[ret_idx]), 64'(retire_we));
        check_val("retire_fault", 64'(v_exp_fault[ret_idx]), 64'(retire_fault));
        // load data of a faulting access is undefined
        if (!v_exp_fault[ret_idx]) begin
          check_val("retire_data", v_exp_data[ret_idx], retire_data);
        end
        ret_idx = ret_idx + 1;
      end
      held       = retire_valid && !retire_ready;
      held_pc    = retire_pc;
      held_inst  = retire_inst;
      held_rd    = retire_rd;
      held_we    = retire_we;
      held_data  = retire_data;
      held_fault = retire_fault;
    end
  end

  initial begin
    int accepted;
    int waited;
    rst           = 1'b1;
    ex_valid      = 1'b0;
    ex_pc         = '0;
    ex_inst       = '0;
    ex_addr       = '0;
    ex_store_data = '0;
    ex_result     = '0;
    ex_csr_data   = '0;
    ex_load_op    = LOAD_NONE;
    ex_store_op   = STORE_NONE;
    ex_rd         = '0;
    ex_rd_we      = 1'b0;
    ex_wb_sel     = WB_SEL_ALU;
    retire_ready  = 1'b0;
    ret_idx       = 0;
    held          = 1'b0;
    load_vectors();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < n_vec; i++) begin
      ex_valid      <= 1'b1;
      ex_pc         <= v_pc[i];
      ex_inst       <= v_inst[i];
      ex_addr       <= v_addr[i];
      ex_store_data <= v_sdata[i];
      ex_result     <= v_result[i];
      ex_csr_data   <= v_csr[i];
      ex_load_op    <= load_op_e'(v_lop[i]);
      ex_store_op   <= store_op_e'(v_sop[i]);
      ex_rd         <= v_rd[i];
      ex_rd_we      <= v_rd_we[i];
      ex_wb_sel     <= wb_sel_e'(v_wb_sel[i]);
      accepted = 0;
      waited   = 0;
      while (accepted == 0) begin
        @(posedge clk);
        if (mem_allowin) begin
          accepted = 1;
        end else begin
          // stage still holds the previous entry
          if (i > 0 && v_lop[i-1] == 3'd0 && v_sop[i-1] == 3'd0) begin
            check_val("fwd_rd", 64'(v_rd[i-1]), 64'(fwd_rd));
            check_val("fwd_we", 64'(v_rd_we[i-1]), 64'(fwd_we));
            check_val("fwd_data", v_exp_data[i-1], fwd_data);
          end
          waited = waited + 1;
          if (waited > ACCEPT_LIMIT) abort_run("timeout waiting for mem_allowin");
        end
      end
    end
    ex_valid <= 1'b0;
    waited = 0;
    while (ret_idx < n_vec) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > RETIRE_LIMIT) abort_run("timeout waiting for the remaining retirements");
    end
    // a few idle cycles so a duplicate retirement would still be caught
    repeat (8) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule
